/* design/matrix_cfg.svh */
/* Frame geometry shared by every block of the matrix frame loader.
   Include this header wherever frame sizes or field widths are needed. */
`ifndef MATRIX_CFG_SVH
`define MATRIX_CFG_SVH

// ######################################################################
// Frame geometry
// ######################################################################
`define MATRIX_PIXEL_WIDTH      8
`define MATRIX_PIXEL_HEIGHT     4
`define MATRIX_BYTES_PER_PIXEL  3

// ######################################################################
// Derived sizes
// ######################################################################
`define MATRIX_FRAME_BYTES (`MATRIX_PIXEL_WIDTH * `MATRIX_PIXEL_HEIGHT * `MATRIX_BYTES_PER_PIXEL)
`define MATRIX_ADDR_BITS   $clog2(`MATRIX_FRAME_BYTES)
`define MATRIX_ROW_BITS    ((`MATRIX_PIXEL_HEIGHT > 1) ? $clog2(`MATRIX_PIXEL_HEIGHT) : 1)
`define MATRIX_COL_BITS    ((`MATRIX_PIXEL_WIDTH > 1) ? $clog2(`MATRIX_PIXEL_WIDTH) : 1)
`define MATRIX_BYTE_BITS   ((`MATRIX_BYTES_PER_PIXEL > 1) ? $clog2(`MATRIX_BYTES_PER_PIXEL) : 1)

`endif

/* design/matrix_pkg.sv */
/* Types shared by the frame loader blocks: opcodes, FSM states and the
   structs carried between the dispatcher, the handlers and the RAM arbiter. */
`include "matrix_cfg.svh"

package matrix_pkg;

    // ##################################################################
    // Field widths
    // ##################################################################
    typedef logic [`MATRIX_ROW_BITS-1:0]  row_t;
    typedef logic [`MATRIX_COL_BITS-1:0]  col_t;
    typedef logic [`MATRIX_BYTE_BITS-1:0] byte_idx_t;
    typedef logic [`MATRIX_ADDR_BITS-1:0] addr_t;

    // ##################################################################
    // Opcodes and states
    // ##################################################################
    typedef enum logic [7:0] {
        OP_NOP       = 8'h00,
        OP_READFRAME = 8'h01,
        OP_FILL      = 8'h02
    } opcode_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READFRAME,
        ST_FILL
    } dispatch_state_e;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_RUN,
        LD_DONE
    } loader_state_e;

    // ##################################################################
    // Transfer structs
    // ##################################################################
    typedef struct packed {
        logic       strobe;
        logic [7:0] data;
    } byte_stb_t;

    typedef struct packed {
        logic       strobe;
        row_t       row;
        col_t       column;
        byte_idx_t  byte_idx;
        logic [7:0] data;
    } pix_wr_t;

    typedef struct packed {
        logic  strobe;
        addr_t addr;
    } ram_rd_req_t;

endpackage

/* design/cmd_dispatch.sv */
/* Command dispatcher. Decodes the opcode byte of each host command and
   routes the following bytes to the matching handler until it reports done. */
`timescale 1ns/1ps
`include "matrix_cfg.svh"

module cmd_dispatch (
    input  logic                  clk,
    input  logic                  reset,
    input  matrix_pkg::byte_stb_t byte_in,
    input  logic                  ld_done,
    input  logic                  fill_done,
    output matrix_pkg::byte_stb_t frame_bytes,
    output matrix_pkg::byte_stb_t fill_bytes,
    output logic                  busy,
    output logic                  frame_done
);
    import matrix_pkg::*;

    dispatch_state_e state;

    // ##################################################################
    // Opcode decode and handler tracking
    // ##################################################################
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (byte_in.strobe) begin
                        case (opcode_e'(byte_in.data))
                            OP_READFRAME: state <= ST_READFRAME;
                            OP_FILL:      state <= ST_FILL;
                            OP_NOP:       state <= ST_IDLE;
                            default:      state <= ST_IDLE; // Unknown opcodes are dropped.
                        endcase
                    end
                end
                ST_READFRAME: begin
                    if (ld_done) begin
                        state      <= ST_IDLE;
                        frame_done <= 1'b1;
                    end
                end
                ST_FILL: begin
                    if (fill_done) begin
                        state      <= ST_IDLE;
                        frame_done <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ##################################################################
    // Byte routing
    // ##################################################################
    always_comb begin
        frame_bytes.strobe = byte_in.strobe && (state == ST_READFRAME);
        frame_bytes.data   = byte_in.data;
        fill_bytes.strobe  = byte_in.strobe && (state == ST_FILL);
        fill_bytes.data    = byte_in.data;
    end

    assign busy = (state != ST_IDLE); // High for the whole command.

endmodule

/* design/cmd_readframe.sv */
/* READFRAME handler. Stores each payload byte at the next pixel position,
   counting down from the last row, column and colour byte. */
`timescale 1ns/1ps
`include "matrix_cfg.svh"

module cmd_readframe (
    input  logic                  clk,
    input  logic                  reset,
    input  matrix_pkg::byte_stb_t frame_bytes,
    output matrix_pkg::pix_wr_t   ld_wr,
    output logic                  done
);
    import matrix_pkg::*;

    loader_state_e state;
    logic          wr_stb;
    row_t          row_q;
    col_t          col_q;
    byte_idx_t     idx_q;
    logic [7:0]    data_q;
    row_t          row_nxt;
    col_t          col_nxt;
    byte_idx_t     idx_nxt;
    logic          nxt_last;

    // ##################################################################
    // Next position steps byte index first, then column, then row
    // ##################################################################
    always_comb begin
        row_nxt = row_q;
        col_nxt = col_q;
        idx_nxt = idx_q;
        if (idx_q != '0) begin
            idx_nxt = idx_q - 1'b1;
        end else begin
            idx_nxt = byte_idx_t'(`MATRIX_BYTES_PER_PIXEL - 1);
            if (col_q != '0) begin
                col_nxt = col_q - 1'b1;
            end else begin
                col_nxt = col_t'(`MATRIX_PIXEL_WIDTH - 1);
                row_nxt = row_q - 1'b1;
            end
        end
        nxt_last = (row_nxt == '0) && (col_nxt == '0) && (idx_nxt == '0);
    end

    // ##################################################################
    // Loader FSM
    // ##################################################################
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= LD_IDLE;
            wr_stb <= 1'b0;
        end else begin
            case (state)
                LD_IDLE: begin
                    wr_stb <= frame_bytes.strobe;
                    if (frame_bytes.strobe) state <= LD_RUN;
                end
                LD_RUN: begin
                    wr_stb <= frame_bytes.strobe;
                    if (frame_bytes.strobe && nxt_last) state <= LD_DONE; // Final byte.
                end
                LD_DONE: begin
                    wr_stb <= 1'b0;
                    state  <= LD_IDLE;
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (frame_bytes.strobe && (state == LD_IDLE)) begin
            row_q  <= row_t'(`MATRIX_PIXEL_HEIGHT - 1);
            col_q  <= col_t'(`MATRIX_PIXEL_WIDTH - 1);
            idx_q  <= byte_idx_t'(`MATRIX_BYTES_PER_PIXEL - 1);
            data_q <= frame_bytes.data;
        end else if (frame_bytes.strobe && (state == LD_RUN)) begin
            row_q  <= row_nxt;
            col_q  <= col_nxt;
            idx_q  <= idx_nxt;
            data_q <= frame_bytes.data;
        end
    end

    assign ld_wr = '{strobe: wr_stb, row: row_q, column: col_q, byte_idx: idx_q, data: data_q};
    assign done  = (state == LD_DONE);

endmodule

/* design/cmd_fill.sv */
/* FILL handler. Collects one colour, then writes it over the whole frame
   one byte per cycle in the same descending order as READFRAME. */
`timescale 1ns/1ps
`include "matrix_cfg.svh"

module cmd_fill (
    input  logic                  clk,
    input  logic                  reset,
    input  matrix_pkg::byte_stb_t fill_bytes,
    output matrix_pkg::pix_wr_t   fill_wr,
    output logic                  done
);
    import matrix_pkg::*;

    loader_state_e state;
    byte_idx_t     colour_cnt;
    logic          wr_stb;
    logic [`MATRIX_BYTES_PER_PIXEL-1:0][7:0] colour;
    row_t          row_q;
    col_t          col_q;
    byte_idx_t     idx_q;
    logic [7:0]    data_q;
    row_t          row_nxt;
    col_t          col_nxt;
    byte_idx_t     idx_nxt;
    logic          start;

    assign start = fill_bytes.strobe && (state == LD_IDLE)
                   && (colour_cnt == byte_idx_t'(`MATRIX_BYTES_PER_PIXEL - 1));

    always_comb begin
        row_nxt = row_q;
        col_nxt = col_q;
        idx_nxt = idx_q - 1'b1;
        if (idx_q == '0) begin
            idx_nxt = byte_idx_t'(`MATRIX_BYTES_PER_PIXEL - 1);
            col_nxt = (col_q == '0) ? col_t'(`MATRIX_PIXEL_WIDTH - 1) : col_q - 1'b1;
            if (col_q == '0) row_nxt = row_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= LD_IDLE;
            colour_cnt <= '0;
            wr_stb     <= 1'b0;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (fill_bytes.strobe) colour_cnt <= start ? '0 : colour_cnt + 1'b1;
                    wr_stb <= start;
                    if (start) state <= LD_RUN;
                end
                LD_RUN: if ((row_nxt == '0) && (col_nxt == '0) && (idx_nxt == '0)) begin
                    state <= LD_DONE; // Last address goes out now.
                end
                default: begin
                    wr_stb <= 1'b0;
                    state  <= LD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fill_bytes.strobe && (state == LD_IDLE)) begin
            for (int i = 0; i < `MATRIX_BYTES_PER_PIXEL - 1; i++) colour[i] <= colour[i+1];
            colour[`MATRIX_BYTES_PER_PIXEL-1] <= fill_bytes.data; // First byte ends at index 0.
        end
        if (start) begin
            {row_q, col_q, idx_q} <= {row_t'(`MATRIX_PIXEL_HEIGHT - 1),
                col_t'(`MATRIX_PIXEL_WIDTH - 1), byte_idx_t'(`MATRIX_BYTES_PER_PIXEL - 1)};
            data_q <= fill_bytes.data;
        end else if (state == LD_RUN) begin
            {row_q, col_q, idx_q} <= {row_nxt, col_nxt, idx_nxt};
            data_q <= colour[idx_nxt];
        end
    end

    assign fill_wr = '{strobe: wr_stb, row: row_q, column: col_q, byte_idx: idx_q, data: data_q};
    assign done    = (state == LD_DONE);

endmodule

/* design/frame_ram_arbiter.sv */
/* Frame RAM arbiter. Puts the active pixel writer on the RAM port and slots
   the host readback into cycles where no write is in flight. */
`timescale 1ns/1ps
`include "matrix_cfg.svh"

module frame_ram_arbiter (
    input  logic                        clk,
    input  logic                        reset,
    input  matrix_pkg::pix_wr_t         ld_wr,
    input  matrix_pkg::pix_wr_t         fill_wr,
    input  matrix_pkg::ram_rd_req_t     rd_req,
    input  logic [7:0]                  ram_rdata,
    output logic                        ram_we,
    output logic                        ram_en,
    output logic [`MATRIX_ADDR_BITS-1:0] ram_addr,
    output logic [7:0]                  ram_wdata,
    output logic [7:0]                  rd_data,
    output logic                        rd_valid
);
    import matrix_pkg::*;

    pix_wr_t wr;
    addr_t   wr_addr;
    logic    wr_active;
    logic    pend_valid;
    addr_t   pend_addr;
    addr_t   rd_addr;
    logic    rd_serve;

    always_comb begin
        wr        = ld_wr.strobe ? ld_wr : fill_wr; // Loader wins a collision.
        wr_active = ld_wr.strobe || fill_wr.strobe;
        wr_addr   = addr_t'((wr.row * `MATRIX_PIXEL_WIDTH + wr.column) * `MATRIX_BYTES_PER_PIXEL
                            + wr.byte_idx);
        rd_addr   = pend_valid ? pend_addr : rd_req.addr;
        rd_serve  = !wr_active && (pend_valid || rd_req.strobe);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
            rd_valid   <= 1'b0;
        end else begin
            pend_valid <= (pend_valid || rd_req.strobe) && wr_active;
            rd_valid   <= rd_serve; // Lines up with the RAM output register.
        end
        if (rd_req.strobe) pend_addr <= rd_req.addr;
    end

    assign ram_we    = wr_active;
    assign ram_en    = wr_active || rd_serve;
    assign ram_addr  = wr_active ? wr_addr : rd_addr;
    assign ram_wdata = wr.data;
    assign rd_data   = ram_rdata;

endmodule

/* design/frame_ram.sv */
/* Single-port frame buffer, one byte per location. Writes when enabled
   with the write enable set, otherwise returns a registered read. */
`timescale 1ns/1ps
`include "matrix_cfg.svh"

module frame_ram (
    input  logic                         clk,
    input  logic                         ram_en,
    input  logic                         ram_we,
    input  logic [`MATRIX_ADDR_BITS-1:0] ram_addr,
    input  logic [7:0]                   ram_wdata,
    output logic [7:0]                   ram_rdata
);

    logic [7:0] mem [`MATRIX_FRAME_BYTES];

    // ##################################################################
    // Storage
    // ##################################################################
    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_addr] <= ram_wdata;
            end else begin
                ram_rdata <= mem[ram_addr]; // One cycle read latency.
            end
        end
    end

endmodule

/* design/matrix_ctrl_top.sv */
/* Frame loading top level. Connects the command dispatcher, both frame
   handlers and the arbitrated frame RAM with its host readback port. */
`timescale 1ns/1ps
`include "matrix_cfg.svh"

module matrix_ctrl_top (
    input  logic                    clk,
    input  logic                    reset,
    input  matrix_pkg::byte_stb_t   byte_in,
    input  matrix_pkg::ram_rd_req_t rd_req,
    output logic                    busy,
    output logic                    frame_done,
    output logic [7:0]              rd_data,
    output logic                    rd_valid
);
    import matrix_pkg::*;

    byte_stb_t  frame_bytes;
    byte_stb_t  fill_bytes;
    pix_wr_t    ld_wr;
    pix_wr_t    fill_wr;
    logic       ld_done;
    logic       fill_done;
    logic       ram_we;
    logic       ram_en;
    addr_t      ram_addr;
    logic [7:0] ram_wdata;
    logic [7:0] ram_rdata;

    // ##################################################################
    // Command path
    // ##################################################################
    cmd_dispatch u_dispatch (
        .clk, .reset, .byte_in, .ld_done, .fill_done,
        .frame_bytes, .fill_bytes, .busy, .frame_done
    );

    cmd_readframe u_readframe (
        .clk, .reset, .frame_bytes, .ld_wr, .done(ld_done)
    );

    cmd_fill u_fill (
        .clk, .reset, .fill_bytes, .fill_wr, .done(fill_done)
    );

    // ##################################################################
    // Frame memory
    // ##################################################################
    frame_ram_arbiter u_arbiter (
        .clk, .reset, .ld_wr, .fill_wr, .rd_req, .ram_rdata,
        .ram_we, .ram_en, .ram_addr, .ram_wdata, .rd_data, .rd_valid
    );

    frame_ram u_ram (
        .clk,
        .ram_en,
        .ram_we,
        .ram_addr,
        .ram_wdata,
        .ram_rdata
    );

endmodule

/* verification/matrix_ctrl_chk.sv */
/* Protocol assertions for the frame loader top level, attached to it
   by the bind below the module. */
`timescale 1ns/1ps

module matrix_ctrl_chk (
    input logic                    clk,
    input logic                    reset,
    input logic                    busy,
    input logic                    frame_done,
    input logic                    rd_valid,
    input matrix_pkg::ram_rd_req_t rd_req,
    input matrix_pkg::pix_wr_t     ld_wr,
    input matrix_pkg::pix_wr_t     fill_wr
);
    import matrix_pkg::*;

    int         fail_cnt = 0;
    logic [3:0] quiet_cnt;
    logic       rd_open;

    always_ff @(posedge clk) begin
        if (reset) begin
            quiet_cnt <= '0;
            rd_open   <= 1'b0;
        end else begin
            if (quiet_cnt < 4'd8) quiet_cnt <= quiet_cnt + 4'd1; // Cycles since reset.
            if (rd_req.strobe) rd_open <= 1'b1;
            else if (rd_valid) rd_open <= 1'b0;
        end
    end

    // ##################################################################
    // Properties
    // ##################################################################
    done_pulse: assert property (@(posedge clk) disable iff (reset)
        frame_done |=> !frame_done)
        else begin
            fail_cnt++;
            $error("frame_done stayed high for more than one cycle");
        end

    quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        (quiet_cnt < 4'd8) |-> !busy)
        else begin
            fail_cnt++;
            $error("busy went high within 8 cycles of reset");
        end

    read_has_request: assert property (@(posedge clk) disable iff (reset)
        rd_valid |-> rd_open)
        else begin
            fail_cnt++;
            $error("rd_valid arrived with no read outstanding");
        end

    single_writer: assert property (@(posedge clk) disable iff (reset)
        !(ld_wr.strobe && fill_wr.strobe))
        else begin
            fail_cnt++;
            $error("loader and fill engine wrote in the same cycle");
        end

    one_read_pending: assert property (@(posedge clk) disable iff (reset)
        rd_req.strobe |-> (!rd_open || rd_valid))
        else begin
            fail_cnt++;
            $error("new read requested while another is pending");
        end

endmodule

bind matrix_ctrl_top matrix_ctrl_chk u_chk (
    .clk(clk), .reset(reset), .busy(busy), .frame_done(frame_done),
    .rd_valid(rd_valid), .rd_req(rd_req), .ld_wr(ld_wr), .fill_wr(fill_wr)
);

/* verification/matrix_ctrl_tb.sv */
/* Testbench for the frame loader top level. Loads and fills frames over
   the byte port and checks every address through the readback port. */
`timescale 1ns/1ps
`include "matrix_cfg.svh"

module matrix_ctrl_tb;
    import matrix_pkg::*;

    localparam int TIMEOUT_CYCLES = 6000;
    localparam int FRAME_BYTES    = `MATRIX_FRAME_BYTES;
    localparam int BPP            = `MATRIX_BYTES_PER_PIXEL;

    logic        clk;
    logic        reset;
    byte_stb_t   byte_in;
    ram_rd_req_t rd_req;
    logic        busy;
    logic        frame_done;
    logic [7:0]  rd_data;
    logic        rd_valid;
    logic [7:0]  model [FRAME_BYTES];
    addr_t       read_addr;
    logic        busy_watch = 1'b0;
    int          reads_done = 0;
    int          done_cnt = 0;
    int          errors = 0;
    int          timeouts = 0;
    int          cycle_cnt = 0;

    matrix_ctrl_top uut (
        .clk(clk), .reset(reset), .byte_in(byte_in), .rd_req(rd_req),
        .busy(busy), .frame_done(frame_done), .rd_data(rd_data), .rd_valid(rd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ######################################################################
    // Helpers
    // ######################################################################
    task automatic fail_value(input string name, input int expected, input int actual);
        errors++;
        $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic addr_t pixel_addr(input int row, input int col, input int idx);
        return addr_t'((row * `MATRIX_PIXEL_WIDTH + col) * BPP + idx);
    endfunction

    // Output checks run at the falling edge.
    always @(negedge clk) begin
        if (frame_done) done_cnt++;
        if (busy_watch && !frame_done) begin
            assert (busy) else fail_value("busy", 1, busy);
        end
        if (rd_valid) begin
            assert (rd_data == model[read_addr]) else fail_value("rd_data", model[read_addr], rd_data);
            reads_done++;
        end
    end

    task automatic drive_byte(input logic [7:0] data, input int max_gap);
        int gap;
        gap = $urandom_range(max_gap, 0);
        byte_in = '{strobe: 1'b1, data: data};
        next_cycle();
        byte_in.strobe = 1'b0;
        repeat (gap) next_cycle();
    endtask

    task automatic request_read(input addr_t addr);
        rd_req    = '{strobe: 1'b1, addr: addr};
        read_addr = addr;
        next_cycle();
        rd_req.strobe = 1'b0;
    endtask

    task automatic wait_reads(input int target);
        int spin;
        spin = 0;
        while (reads_done < target && spin < 200) begin
            next_cycle();
            spin++;
        end
        assert (reads_done == target) else begin
            errors++;
            $display("Read answer missing: %0d of %0d reads returned", reads_done, target);
        end
    endtask

    task automatic wait_done(input int target);
        int spin;
        spin = 0;
        while (done_cnt < target && spin < 300) begin
            next_cycle();
            spin++;
        end
        busy_watch = 1'b0;
        repeat (3) next_cycle();
        assert (done_cnt == target) else fail_value("frame_done count", target, done_cnt);
    endtask

    task automatic check_frame();
        int base;
        base = reads_done;
        for (int a = 0; a < FRAME_BYTES; a++) begin
            request_read(addr_t'(a));
            wait_reads(base + a + 1);
        end
    endtask

    // ######################################################################
    // Commands
    // ######################################################################
    task automatic load_frame();
        logic [7:0] data;
        int         target;
        int         rbase;
        target = done_cnt + 1;
        rbase  = reads_done;
        drive_byte(OP_READFRAME, 3);
        for (int k = 0; k < FRAME_BYTES; k++) begin
            if (k == 60) request_read(pixel_addr(2, 5, 1)); // Written as byte 31.
            data = 8'($urandom);
            model[FRAME_BYTES - 1 - k] = data; // Descending address order.
            drive_byte(data, 3);
        end
        wait_reads(rbase + 1);
        wait_done(target);
    endtask

    task automatic fill_frame(input logic [BPP-1:0][7:0] colour, input bit inject);
        int target;
        target = done_cnt + 1;
        drive_byte(OP_FILL, 0);
        busy_watch = 1'b1;
        for (int i = 0; i < BPP; i++) drive_byte(colour[i], (i == BPP - 1) ? 0 : 3);
        for (int a = 0; a < FRAME_BYTES; a++) model[a] = colour[a % BPP];
        if (inject) begin
            drive_byte(OP_READFRAME, 1); // Lands in the write phase.
            repeat (4) drive_byte(8'($urandom), 2);
        end
        wait_done(target);
    endtask

    task automatic send_ignored(input logic [7:0] opcode);
        drive_byte(opcode, 0);
        repeat (3) begin
            assert (!busy) else fail_value("busy", 0, busy);
            next_cycle();
        end
    endtask

    task automatic finish_run();
        int chk_fails;
        chk_fails = uut.u_chk.fail_cnt;
        $display("Errors: checks %0d, assertions %0d, timeouts %0d", errors, chk_fails, timeouts);
        if (errors + chk_fails + timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // ######################################################################
    // Sequence
    // ######################################################################
    initial begin
        void'($urandom(15583));
        reset     = 1'b1;
        byte_in   = '0;
        rd_req    = '0;
        read_addr = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (10) next_cycle();
        load_frame();
        check_frame();
        send_ignored(OP_NOP);
        send_ignored(8'h7e);
        check_frame();
        fill_frame({8'he7, 8'h81, 8'h3c}, 1'b0);
        check_frame();
        fill_frame({8'h0f, 8'ha5, 8'h5a}, 1'b1);
        check_frame();
        finish_run();
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        timeouts++;
        finish_run();
    end

endmodule

/* build.f */
+incdir+design
design/matrix_pkg.sv
design/cmd_dispatch.sv
design/cmd_readframe.sv
design/cmd_fill.sv
design/frame_ram_arbiter.sv
design/frame_ram.sv
design/matrix_ctrl_top.sv
verification/matrix_ctrl_chk.sv
verification/matrix_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# Compile the frame loader testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module matrix_ctrl_tb \
    -f build.f -o matrix_sim > build.log 2>&1 \
    && ./obj_dir/matrix_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null || { cat build.log; echo "Build or run did not produce a log"; exit 1; }
grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log && echo "Simulation passed" \
    || { echo "Simulation ended without a result line"; exit 1; }
